// ==== Makefile ====
TOP = tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "Testbench failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Testbench passed" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== access_ctrl.sv ====
`timescale 1ns/1ps

module access_ctrl import cache_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               replace_lru,
  input  logic               not_empty,
  input  cache_req_t         head,
  output logic               pop,
  output lookup_t            l1_lookup,
  output lookup_t            l2_lookup,
  input  logic               l1_hit,
  input  logic               l2_hit,
  input  logic [l1_ways-1:0] l1_hit_way,
  input  logic [l2_ways-1:0] l2_hit_way,
  output update_t            l1_update,
  output update_t            l2_update,
  output logic               resp_valid,
  output cache_resp_t        resp,
  output stat_event_t        stat_event
);

  typedef enum logic [2:0] {idle, l1_look, l2_look, update, respond} state_e;

  state_e             state;
  state_e             next_state;
  cache_req_t         cur_req;
  logic               lru;
  logic               l1_hit_q;
  logic               l2_hit_q;
  logic [l1_ways-1:0] l1_way_q;
  logic [l2_ways-1:0] l2_way_q;
  lookup_t            l1_key;
  lookup_t            l2_key;
  logic               l1_upd_now;
  logic               l2_upd_now;

  // Miss inserts, a hit promotes only under LRU
  function automatic update_op_e choose_op(input logic was_hit, input logic use_lru);
    if (!was_hit) begin
      return upd_insert;
    end
    return use_lru ? upd_promote : upd_none;
  endfunction

  //////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////

  // One request at a time, the next pop waits for the response
  always_comb begin
    next_state = state;
    case (state)
      idle:    if (not_empty) next_state = l1_look;
      l1_look: next_state = l1_hit ? respond : l2_look;
      l2_look: next_state = update;
      update:  next_state = respond;
      respond: next_state = idle;
      default: next_state = idle;
    endcase
  end

  assign pop = (state == idle) && not_empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= idle;
      lru      <= 1'b0;
      l1_hit_q <= 1'b0;
      l2_hit_q <= 1'b0;
    end else begin
      state <= next_state;
      // Policy is sampled once per request
      if (pop) begin
        lru      <= replace_lru;
        l2_hit_q <= 1'b0;
      end
      if (state == l1_look) begin
        l1_hit_q <= l1_hit;
      end
      if (state == l2_look) begin
        l2_hit_q <= l2_hit;
      end
    end
  end

  // Request and hit ways are payload
  always_ff @(posedge clk) begin
    if (pop) begin
      cur_req <= head;
    end
    if (state == l1_look) begin
      l1_way_q <= l1_hit_way;
    end
    if (state == l2_look) begin
      l2_way_q <= l2_hit_way;
    end
  end

  //////////////////////////////////////////////////
  // Tag store traffic
  //////////////////////////////////////////////////

  // L1 is looked up straight from the queue head in the pop cycle
  always_comb begin
    l1_lookup       = l1_split(head.addr);
    l1_lookup.valid = pop;
  end

  // L2 is only looked up on an L1 miss
  always_comb begin
    l2_lookup       = l2_split(cur_req.addr);
    l2_lookup.valid = (state == l1_look) && !l1_hit;
  end

  assign l1_key = l1_split(cur_req.addr);
  assign l2_key = l2_split(cur_req.addr);

  // An L1 hit updates in the response cycle, a miss updates both levels together
  assign l1_upd_now = (state == update) || ((state == respond) && l1_hit_q);
  assign l2_upd_now = (state == update);

  always_comb begin
    l1_update.op  = l1_upd_now ? choose_op(l1_hit_q, lru) : upd_none;
    l1_update.set = l1_key.set;
    l1_update.tag = l1_key.tag;
    l1_update.way = l2_ways'(l1_way_q);
    l2_update.op  = l2_upd_now ? choose_op(l2_hit_q, lru) : upd_none;
    l2_update.set = l2_key.set;
    l2_update.tag = l2_key.tag;
    l2_update.way = l2_way_q;
  end

  // Response and statistics event
  assign resp_valid          = (state == respond);
  assign resp.l1_hit         = l1_hit_q;
  assign resp.l2_hit         = l2_hit_q;
  assign stat_event.valid    = resp_valid;
  assign stat_event.is_write = cur_req.is_write;
  assign stat_event.l1_hit   = l1_hit_q;
  assign stat_event.l2_hit   = l2_hit_q;

  // Each request ends with exactly one single cycle response
  a_resp_pulse: assert property (@(posedge clk) disable iff (reset)
    resp_valid |=> !resp_valid);

endmodule

// ==== cache_hier_top.sv ====
`timescale 1ns/1ps

module cache_hier_top import cache_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        replace_lru,
  input  logic        req_valid,
  input  cache_req_t  req,
  output logic        credit_return,
  output logic        resp_valid,
  output cache_resp_t resp,
  output stats_t      stats
);

  cache_req_t         fifo_head;
  logic               fifo_not_empty;
  logic               pop;
  lookup_t            l1_lookup;
  lookup_t            l2_lookup;
  logic               l1_hit;
  logic               l2_hit;
  logic [l1_ways-1:0] l1_hit_way;
  logic [l2_ways-1:0] l2_hit_way;
  update_t            l1_update;
  update_t            l2_update;
  stat_event_t        stat_event;

  // Credit-controlled queue in front of the controller
  req_fifo i_req_fifo (
    .clk           (clk),
    .reset         (reset),
    .push          (req_valid),
    .push_data     (req),
    .pop           (pop),
    .head          (fifo_head),
    .not_empty     (fifo_not_empty),
    .credit_return (credit_return)
  );

  access_ctrl i_access_ctrl (
    .clk         (clk),
    .reset       (reset),
    .replace_lru (replace_lru),
    .not_empty   (fifo_not_empty),
    .head        (fifo_head),
    .pop         (pop),
    .l1_lookup   (l1_lookup),
    .l2_lookup   (l2_lookup),
    .l1_hit      (l1_hit),
    .l2_hit      (l2_hit),
    .l1_hit_way  (l1_hit_way),
    .l2_hit_way  (l2_hit_way),
    .l1_update   (l1_update),
    .l2_update   (l2_update),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .stat_event  (stat_event)
  );

  // Same store for both levels, only geometry and tag width differ
  tag_store #(.tag_t(l1_tag_t), .num_sets(l1_sets), .num_ways(l1_ways)) i_l1_tags (
    .clk     (clk),
    .reset   (reset),
    .lookup  (l1_lookup),
    .hit     (l1_hit),
    .hit_way (l1_hit_way),
    .update  (l1_update)
  );

  tag_store #(.tag_t(l2_tag_t), .num_sets(l2_sets), .num_ways(l2_ways)) i_l2_tags (
    .clk     (clk),
    .reset   (reset),
    .lookup  (l2_lookup),
    .hit     (l2_hit),
    .hit_way (l2_hit_way),
    .update  (l2_update)
  );

  stat_counters i_stat_counters (
    .clk        (clk),
    .reset      (reset),
    .stat_event (stat_event),
    .stats      (stats)
  );

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////

  localparam int addr_width  = 32;
  localparam int block_bytes = 64;
  localparam int offset_bits = $clog2(block_bytes);

  localparam int l1_sets     = 8;
  localparam int l1_ways     = 4;
  localparam int l1_set_bits = 3;
  localparam int l2_sets     = 16;
  localparam int l2_ways     = 8;
  localparam int l2_set_bits = 4;

  localparam int l1_tag_bits = addr_width - offset_bits - l1_set_bits;
  localparam int l2_tag_bits = addr_width - offset_bits - l2_set_bits;

  // L1 has fewer sets and so carries the wider tag
  localparam int max_tag_bits = l1_tag_bits;

  // Request queue depth, which is also the sender's starting credit
  localparam int req_depth    = 4;
  localparam int req_ptr_bits = $clog2(req_depth);
  localparam int req_cnt_bits = $clog2(req_depth + 1);

  localparam int stat_width = 16;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [l1_tag_bits-1:0] l1_tag_t;
  typedef logic [l2_tag_bits-1:0] l2_tag_t;

  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic                  is_write;
  } cache_req_t;

  typedef struct packed {
    logic l1_hit;
    logic l2_hit;
  } cache_resp_t;

  // Set and tag are sized for the largest level and each store takes the low bits
  typedef struct packed {
    logic                    valid;
    logic [l2_set_bits-1:0]  set;
    logic [max_tag_bits-1:0] tag;
  } lookup_t;

  typedef enum logic [1:0] {
    upd_none,
    upd_insert,
    upd_promote
  } update_op_e;

  typedef struct packed {
    update_op_e              op;
    logic [l2_set_bits-1:0]  set;
    logic [max_tag_bits-1:0] tag;
    logic [l2_ways-1:0]      way;
  } update_t;

  typedef struct packed {
    logic valid;
    logic is_write;
    logic l1_hit;
    logic l2_hit;
  } stat_event_t;

  typedef struct packed {
    logic [stat_width-1:0] l1_hits;
    logic [stat_width-1:0] l1_misses;
    logic [stat_width-1:0] l2_hits;
    logic [stat_width-1:0] l2_misses;
    logic [stat_width-1:0] reads;
    logic [stat_width-1:0] writes;
  } stats_t;

  // Address layout is offset in the low bits, then set index, then tag
  function automatic lookup_t l1_split(input logic [addr_width-1:0] addr);
    lookup_t lk;
    lk       = '0;
    lk.valid = 1'b1;
    lk.set   = l2_set_bits'(addr[offset_bits +: l1_set_bits]);
    lk.tag   = max_tag_bits'(addr[addr_width-1 -: l1_tag_bits]);
    return lk;
  endfunction

  function automatic lookup_t l2_split(input logic [addr_width-1:0] addr);
    lookup_t lk;
    lk       = '0;
    lk.valid = 1'b1;
    lk.set   = l2_set_bits'(addr[offset_bits +: l2_set_bits]);
    lk.tag   = max_tag_bits'(addr[addr_width-1 -: l2_tag_bits]);
    return lk;
  endfunction

endpackage

// ==== req_fifo.sv ====
`timescale 1ns/1ps

module req_fifo import cache_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       push,
  input  cache_req_t push_data,
  input  logic       pop,
  output cache_req_t head,
  output logic       not_empty,
  output logic       credit_return
);

  cache_req_t mem [req_depth];

  logic [req_ptr_bits-1:0] wr_ptr;
  logic [req_ptr_bits-1:0] rd_ptr;
  logic [req_cnt_bits-1:0] count;
  logic                    do_pop;

  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];

  // A pop on an empty queue is ignored
  assign do_pop = pop && not_empty;

  // Each entry that leaves frees one slot, so one credit goes back
  assign credit_return = do_pop;

  // Storage is written at the tail, with no reset on the payload
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The sender's credit count must keep pushes out of a full queue
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> (count != req_cnt_bits'(req_depth)));

endmodule

// ==== sources.f ====
cache_pkg.sv
req_fifo.sv
tag_store.sv
access_ctrl.sv
stat_counters.sv
cache_hier_top.sv
tb_checker.sv
tb_top.sv

// ==== stat_counters.sv ====
`timescale 1ns/1ps

module stat_counters import cache_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  stat_event_t stat_event,
  output stats_t      stats
);

  // Each finished request bumps one counter per level it reached
  always_ff @(posedge clk) begin
    if (reset) begin
      stats <= '0;
    end else if (stat_event.valid) begin
      if (stat_event.l1_hit) begin
        stats.l1_hits <= stats.l1_hits + stat_width'(1);
      end else begin
        stats.l1_misses <= stats.l1_misses + stat_width'(1);
        // L2 only sees the requests that missed in L1
        if (stat_event.l2_hit) begin
          stats.l2_hits <= stats.l2_hits + stat_width'(1);
        end else begin
          stats.l2_misses <= stats.l2_misses + stat_width'(1);
        end
      end
      // Write-through counts a write once whatever the hit result
      if (stat_event.is_write) begin
        stats.writes <= stats.writes + stat_width'(1);
      end else begin
        stats.reads <= stats.reads + stat_width'(1);
      end
    end
  end

endmodule

// ==== tag_store.sv ====
`timescale 1ns/1ps

module tag_store import cache_pkg::*; #(
  parameter type tag_t    = l2_tag_t,
  parameter int  num_sets = l2_sets,
  parameter int  num_ways = l2_ways
) (
  input  logic                clk,
  input  logic                reset,
  input  lookup_t             lookup,
  output logic                hit,
  output logic [num_ways-1:0] hit_way,
  input  update_t             update
);

  // Each set is an ordered list where way 0 holds the most recent entry
  tag_t                tag_mem   [num_sets][num_ways];
  logic [num_ways-1:0] valid_mem [num_sets];

  logic [$clog2(num_sets)-1:0] look_set;
  logic [$clog2(num_sets)-1:0] upd_set;
  tag_t                        look_tag;
  tag_t                        upd_tag;
  logic [num_ways-1:0]         match;
  logic [num_ways-1:0]         upd_way;
  logic [num_ways-1:0]         shift_en;
  logic                        seen;
  logic                        do_write;

  // Take the low bits this level needs from the shared fields
  assign look_set = lookup.set[$clog2(num_sets)-1:0];
  assign look_tag = tag_t'(lookup.tag[$bits(tag_t)-1:0]);
  assign upd_set  = update.set[$clog2(num_sets)-1:0];
  assign upd_tag  = tag_t'(update.tag[$bits(tag_t)-1:0]);
  assign upd_way  = update.way[num_ways-1:0];
  assign do_write = (update.op != upd_none);

  // Compare every way of the addressed set in parallel
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      match[w] = valid_mem[look_set][w] && (tag_mem[look_set][w] == look_tag);
    end
  end

  // Lookup result is registered and holds until the next lookup
  always_ff @(posedge clk) begin
    if (reset) begin
      hit     <= 1'b0;
      hit_way <= '0;
    end else if (lookup.valid) begin
      hit     <= |match;
      hit_way <= match;
    end
  end

  // Insert shifts the whole set down by one and drops the last way
  // Promote shifts only the ways above the hit way, so position p moves
  // when the hit sits at p or deeper
  always_comb begin
    seen     = 1'b0;
    shift_en = '0;
    for (int p = num_ways - 1; p >= 1; p--) begin
      seen        = seen | upd_way[p];
      shift_en[p] = (update.op == upd_insert) || ((update.op == upd_promote) && seen);
    end
  end

  // Valid bits are control state and clear on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        valid_mem[s] <= '0;
      end
    end else if (do_write) begin
      for (int p = 1; p < num_ways; p++) begin
        if (shift_en[p]) begin
          valid_mem[upd_set][p] <= valid_mem[upd_set][p-1];
        end
      end
      valid_mem[upd_set][0] <= 1'b1;
    end
  end

  // Tags follow the same shift as the valid bits
  always_ff @(posedge clk) begin
    if (do_write) begin
      for (int p = 1; p < num_ways; p++) begin
        if (shift_en[p]) begin
          tag_mem[upd_set][p] <= tag_mem[upd_set][p-1];
        end
      end
      // Head of the list always takes the requested tag
      tag_mem[upd_set][0] <= upd_tag;
    end
  end

  // A tag lives in at most one way of its set
  a_single_match: assert property (@(posedge clk) disable iff (reset)
    lookup.valid |=> $onehot0(hit_way));

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker import cache_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        replace_lru,
  input  logic        req_valid,
  input  cache_req_t  req,
  input  logic        resp_valid,
  input  cache_resp_t resp,
  input  stats_t      stats,
  input  logic        check_end,
  output int          errors,
  output int          checks,
  output int          pending
);

  // Requests in flight, each with the policy that was active when it entered
  cache_req_t in_flight [$];
  logic       policy_q  [$];

  // Reference tag lists, level 0 is L1 and level 1 is L2
  // Position 0 of each list holds the most recent entry
  logic [addr_width-1:0] ref_tag   [2][l2_sets][l2_ways];
  logic                  ref_valid [2][l2_sets][l2_ways];

  int         n_l1_hit;
  int         n_l1_miss;
  int         n_l2_hit;
  int         n_l2_miss;
  int         n_read;
  int         n_write;
  cache_req_t cur;
  logic       cur_lru;
  logic       exp_l1;
  logic       exp_l2;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Looks up one level and applies the replacement rule to its list
  task automatic model_access(input int lvl, input logic [addr_width-1:0] addr,
                              input logic lru, output logic hit);
    int                    sets;
    int                    ways;
    int                    set;
    int                    way;
    logic [addr_width-1:0] tag;
    sets = (lvl == 0) ? l1_sets : l2_sets;
    ways = (lvl == 0) ? l1_ways : l2_ways;
    // Block offset sits lowest, the set index above it and the tag on top
    set  = int'((addr / block_bytes) % sets);
    tag  = addr / (block_bytes * sets);
    hit  = 1'b0;
    way  = ways - 1;
    for (int w = 0; w < ways; w++) begin
      if (ref_valid[lvl][set][w] && (ref_tag[lvl][set][w] == tag)) begin
        hit = 1'b1;
        way = w;
      end
    end
    // A miss shifts the whole list, an LRU hit shifts only the entries above it
    // A FIFO hit leaves the list alone
    if (!hit || lru) begin
      for (int p = way; p > 0; p--) begin
        ref_tag[lvl][set][p]   = ref_tag[lvl][set][p-1];
        ref_valid[lvl][set][p] = ref_valid[lvl][set][p-1];
      end
      ref_tag[lvl][set][0]   = tag;
      ref_valid[lvl][set][0] = 1'b1;
    end
  endtask

  task automatic compare_count(input string name, input logic [stat_width-1:0] got,
                               input int expected);
    if (got !== stat_width'(expected)) begin
      errors++;
      $display("ERROR at %0t: %s counter is %0d, expected %0d", $time, name, got, expected);
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      in_flight.delete();
      policy_q.delete();
      for (int l = 0; l < 2; l++) begin
        for (int s = 0; s < l2_sets; s++) begin
          for (int w = 0; w < l2_ways; w++) begin
            ref_valid[l][s][w] = 1'b0;
          end
        end
      end
      n_l1_hit  = 0;
      n_l1_miss = 0;
      n_l2_hit  = 0;
      n_l2_miss = 0;
      n_read    = 0;
      n_write   = 0;
      errors    = 0;
      checks    = 0;
      pending   = 0;
    end else begin
      // The policy only changes with every credit home, so the value here
      // is the one the controller samples at pop
      if (req_valid) begin
        in_flight.push_back(req);
        policy_q.push_back(replace_lru);
      end
      if (resp_valid) begin
        if (in_flight.size() == 0) begin
          errors++;
          $display("A response arrived at %0t with no request outstanding", $time);
        end else begin
          cur     = in_flight.pop_front();
          cur_lru = policy_q.pop_front();
          model_access(0, cur.addr, cur_lru, exp_l1);
          exp_l2 = 1'b0;
          if (exp_l1) begin
            n_l1_hit++;
          end else begin
            n_l1_miss++;
            // L2 is consulted and filled only behind an L1 miss
            model_access(1, cur.addr, cur_lru, exp_l2);
            if (exp_l2) begin
              n_l2_hit++;
            end else begin
              n_l2_miss++;
            end
          end
          if (cur.is_write) begin
            n_write++;
          end else begin
            n_read++;
          end
          checks++;
          if ((resp.l1_hit !== exp_l1) || (resp.l2_hit !== exp_l2)) begin
            errors++;
            $display("ERROR at %0t: addr %h gave l1_hit %b l2_hit %b, expected %b %b",
                     $time, cur.addr, resp.l1_hit, resp.l2_hit, exp_l1, exp_l2);
          end
        end
      end
      pending = in_flight.size();
      if (check_end) begin
        compare_count("l1_hits", stats.l1_hits, n_l1_hit);
        compare_count("l1_misses", stats.l1_misses, n_l1_miss);
        compare_count("l2_hits", stats.l2_hits, n_l2_hit);
        compare_count("l2_misses", stats.l2_misses, n_l2_miss);
        compare_count("reads", stats.reads, n_read);
        compare_count("writes", stats.writes, n_write);
        // Every level's hits and misses cover exactly the accesses it saw
        if ((stats.l1_hits + stats.l1_misses != stat_width'(checks)) ||
            (stats.l2_hits + stats.l2_misses != stat_width'(n_l1_miss)) ||
            (stats.reads + stats.writes != stat_width'(checks))) begin
          errors++;
          $display("ERROR at %0t: counter totals do not add up to %0d requests",
                   $time, checks);
        end
      end
    end
  end

endmodule

// ==== tb_top.sv ====
`timescale 1ns/1ps

module tb_top import cache_pkg::*; ();

  localparam int                    wait_limit = 400;
  localparam logic [addr_width-1:0] rand_base  = 32'h1234_0000;
  localparam logic [addr_width-1:0] hot_base   = 32'h5000_0000;
  // Set index 5 at both levels
  localparam logic [addr_width-1:0] evict_base = 32'h6000_0140;

  logic        clk;
  logic        reset;
  logic        replace_lru;
  logic        req_valid;
  cache_req_t  req;
  logic        credit_return;
  logic        resp_valid;
  cache_resp_t resp;
  stats_t      stats;
  logic        check_end;
  int          errors;
  int          checks;
  int          pending;
  int          sent;
  int          returned;
  logic [31:0] rng;

  cache_hier_top i_dut (
    .clk           (clk),
    .reset         (reset),
    .replace_lru   (replace_lru),
    .req_valid     (req_valid),
    .req           (req),
    .credit_return (credit_return),
    .resp_valid    (resp_valid),
    .resp          (resp),
    .stats         (stats)
  );

  tb_checker i_checker (
    .clk         (clk),
    .reset       (reset),
    .replace_lru (replace_lru),
    .req_valid   (req_valid),
    .req         (req),
    .resp_valid  (resp_valid),
    .resp        (resp),
    .stats       (stats),
    .check_end   (check_end),
    .errors      (errors),
    .checks      (checks),
    .pending     (pending)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // One credit comes home per popped queue entry
  always @(posedge clk) begin
    if (reset) begin
      returned <= 0;
    end else if (credit_return) begin
      returned <= returned + 1;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int credits();
    return req_depth - sent + returned;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Testbench failed");
    $finish;
  endtask

  // Spends one credit and holds the request for a single cycle
  task automatic send_req(input logic [addr_width-1:0] addr, input logic wr);
    int waited;
    waited = 0;
    while (credits() == 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > wait_limit) begin
        abort_on_timeout("a credit");
      end
    end
    req_valid    = 1'b1;
    req.addr     = addr;
    req.is_write = wr;
    sent         = sent + 1;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  // All credits home and every request answered
  task automatic drain();
    int waited;
    waited = 0;
    while ((credits() != req_depth) || (pending != 0)) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > wait_limit) begin
        abort_on_timeout("credits and responses to return");
      end
    end
  endtask

  // A small pool of sets and tags so that both levels see hits
  task automatic random_burst(input int count);
    logic [addr_width-1:0] addr;
    logic                  wr;
    for (int i = 0; i < count; i++) begin
      rng  = next_rand(rng);
      addr = rand_base | (rng & 32'h0000_3fff);
      rng  = next_rand(rng);
      wr   = rng[3];
      send_req(addr, wr);
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    reset       = 1'b1;
    replace_lru = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    check_end   = 1'b0;
    sent        = 0;
    rng         = 32'h76da;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    // FIFO replacement under random traffic
    random_burst(150);
    drain();

    // Policy moves only while every credit is home
    replace_lru = 1'b1;
    random_burst(150);
    // Hot tag interleaved with fresh tags of the same set should keep hitting
    send_req(hot_base, 1'b0);
    for (int k = 1; k <= 8; k++) begin
      send_req(hot_base + (k << 10), k[0]);
      send_req(hot_base, 1'b0);
    end
    drain();

    // Five tags through one set push the first out of L1, L2 still holds it
    for (int k = 0; k < 5; k++) begin
      send_req(evict_base + (k << 10), 1'b0);
    end
    send_req(evict_base, 1'b1);
    drain();

    check_end = 1'b1;
    @(posedge clk);
    #1;
    check_end = 1'b0;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
